// File: cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Bus widths
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32
`define CACHE_STRB_W    (`CACHE_DATA_W / 8)     // One strobe per byte lane
`define CACHE_CNT_W     16                      // Hit and miss event counters

// L1 geometry, one word per line
`define CACHE_NUM_SETS  256
`define CACHE_IDX_W     8                       // Set index taken from addr[9:2]
`define CACHE_NUM_WAYS  4
`define CACHE_WAY_W     2
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_IDX_W)   // addr[31:10] plus addr[1:0]

// Saturating age per way
`define CACHE_AGE_W     3
`define CACHE_AGE_MAX   3'(`CACHE_NUM_WAYS - 1)

// L2 backing memory
`define CACHE_L2_LAT    3                       // Request to response in cycles
`define CACHE_L2_DEPTH  4096
`define CACHE_L2_IDX_W  12                      // Word index from addr[13:2]

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // Access size as decoded from PSTRB
    typedef enum logic [1:0] {
        SZ_BYTE,    // Strobe 0001
        SZ_HALF,    // Strobe 0011
        SZ_WORD     // Strobe 1111, also every read
    } access_size_e;

    typedef enum logic [2:0] {
        ST_IDLE,        // Waiting for an APB setup phase
        ST_LOOKUP,      // First access cycle, array tag compare
        ST_FILL_WAIT,   // L2 read outstanding
        ST_WT_WAIT,     // Write-through outstanding
        ST_DONE         // Completion cycle with PREADY
    } ctrl_state_e;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        access_size_e             size;
        logic                     wr;
    } cache_req_t;

    typedef struct packed {
        logic                     valid;    // Single-cycle pulse
        logic                     we;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        access_size_e             size;
    } l2_req_t;

    typedef struct packed {
        logic                     valid;    // Read data or write acknowledge
        logic [`CACHE_DATA_W-1:0] rdata;
    } l2_rsp_t;

    // Lays the low bytes of new_w over old_w according to size
    function automatic logic [`CACHE_DATA_W-1:0] merge_bytes(
        input logic [`CACHE_DATA_W-1:0] old_w,
        input logic [`CACHE_DATA_W-1:0] new_w,
        input access_size_e             size
    );
        case (size)
            SZ_BYTE: return {old_w[`CACHE_DATA_W-1:8], new_w[7:0]};
            SZ_HALF: return {old_w[`CACHE_DATA_W-1:16], new_w[15:0]};
            default: return new_w;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: l1_cache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module l1_cache_array (
    input  logic                      clk,
    input  logic                      rst_i,
    input  cache_pkg::cache_req_t     req_i,          // Current access, held for the whole transfer
    input  logic                      touch_i,        // Hit completed, refresh ages
    input  logic                      wr_hit_i,       // Merge write bytes into the hit way
    input  logic                      fill_i,         // Replace the victim way
    input  logic [`CACHE_DATA_W-1:0]  fill_data_i,    // Word returned by L2
    output logic                      hit_o,
    output logic [`CACHE_DATA_W-1:0]  rd_data_o
);
    import cache_pkg::*;

    // Storage, tags and data carry no reset
    logic [`CACHE_TAG_W-1:0]    tag_mem  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic [`CACHE_DATA_W-1:0]   data_mem [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic [`CACHE_NUM_WAYS-1:0] valid_q  [`CACHE_NUM_SETS];
    logic [`CACHE_AGE_W-1:0]    age_q    [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_IDX_W-1:0]    set_idx;
    logic [`CACHE_WAY_W-1:0]    hit_way;
    logic [`CACHE_WAY_W-1:0]    victim;
    logic [`CACHE_WAY_W-1:0]    upd_way;        // Way that becomes most recently used
    logic [`CACHE_AGE_W-1:0]    max_age;
    logic [`CACHE_DATA_W-1:0]   fill_word;

    // Upper tag bits sit above the index, the two lower ones below it
    assign tag     = {req_i.addr[`CACHE_ADDR_W-1:`CACHE_IDX_W+2], req_i.addr[1:0]};
    assign set_idx = req_i.addr[`CACHE_IDX_W+1:2];

    // Tag compare, first matching valid way wins
    always_comb begin
        hit_o   = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (!hit_o && valid_q[set_idx][w] && tag_mem[set_idx][w] == tag) begin
                hit_o   = 1'b1;
                hit_way = w[`CACHE_WAY_W-1:0];
            end
        end
    end

    assign rd_data_o = hit_o ? data_mem[set_idx][hit_way] : '0;   // Full word, zero on a miss

    // Victim is the oldest way
    always_comb begin
        victim  = '0;
        max_age = age_q[set_idx][0];
        for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
            if (age_q[set_idx][w] > max_age) begin   // Strict compare keeps the lowest way on ties
                max_age = age_q[set_idx][w];
                victim  = w[`CACHE_WAY_W-1:0];
            end
        end
    end

    assign upd_way = fill_i ? victim : hit_way;

    // Write miss merges the new bytes over the L2 word
    assign fill_word = req_i.wr ? merge_bytes(fill_data_i, req_i.wdata, req_i.size)
                                : fill_data_i;

    // Valid bits and ages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (touch_i || fill_i) begin
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                if (w[`CACHE_WAY_W-1:0] == upd_way) begin
                    age_q[set_idx][w] <= '0;                      // Most recently used
                end else if (age_q[set_idx][w] < `CACHE_AGE_MAX) begin
                    age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1; // Others age, saturating
                end
            end
            if (fill_i) begin
                valid_q[set_idx][victim] <= 1'b1;
            end
        end
    end

    // Tag and data writes
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[set_idx][victim]  <= tag;
            data_mem[set_idx][victim] <= fill_word;
        end else if (wr_hit_i) begin
            data_mem[set_idx][hit_way] <= merge_bytes(data_mem[set_idx][hit_way],
                                                      req_i.wdata, req_i.size);
        end
    end

endmodule

`default_nettype wire

// File: l2_backing_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module l2_backing_mem (
    input  logic                 clk,
    input  logic                 rst_i,
    input  cache_pkg::l2_req_t   req_i,     // Always accepted
    output cache_pkg::l2_rsp_t   rsp_o      // Valid CACHE_L2_LAT cycles after the request
);
    import cache_pkg::*;

    // Word store, starts out all zero
    logic [`CACHE_DATA_W-1:0]  mem [`CACHE_L2_DEPTH] = '{default: '0};

    logic [`CACHE_L2_IDX_W-1:0] widx;
    logic [`CACHE_L2_LAT-1:0]   vld_pipe;                   // Shifts toward the MSB
    logic [`CACHE_DATA_W-1:0]   dat_pipe [`CACHE_L2_LAT];

    assign widx = req_i.addr[`CACHE_L2_IDX_W+1:2];          // Aliases above addr[13]

    // Writes land on arrival with their size mask
    always_ff @(posedge clk) begin
        if (req_i.valid && req_i.we) begin
            mem[widx] <= merge_bytes(mem[widx], req_i.wdata, req_i.size);
        end
    end

    // Response valid pipeline
    always_ff @(posedge clk) begin
        if (rst_i) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`CACHE_L2_LAT-2:0], req_i.valid};
        end
    end

    // Read data travels alongside, meaningless for write acks
    always_ff @(posedge clk) begin
        dat_pipe[0] <= mem[widx];
        for (int i = 1; i < `CACHE_L2_LAT; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    assign rsp_o = '{valid: vld_pipe[`CACHE_L2_LAT-1], rdata: dat_pipe[`CACHE_L2_LAT-1]};

endmodule

`default_nettype wire

// File: cache_apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_apb_ctrl (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`CACHE_ADDR_W-1:0]  paddr_i,
    input  logic [`CACHE_DATA_W-1:0]  pwdata_i,
    input  logic [`CACHE_STRB_W-1:0]  pstrb_i,
    output logic [`CACHE_DATA_W-1:0]  prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output cache_pkg::cache_req_t     req_o,
    input  logic                      hit_i,
    input  logic [`CACHE_DATA_W-1:0]  rd_data_i,
    output logic                      touch_o,
    output logic                      wr_hit_o,
    output logic                      fill_o,
    output logic [`CACHE_DATA_W-1:0]  fill_data_o,
    output cache_pkg::l2_req_t        l2_req_o,
    input  cache_pkg::l2_rsp_t        l2_rsp_i,
    output logic [`CACHE_CNT_W-1:0]   hit_count_o,
    output logic [`CACHE_CNT_W-1:0]   miss_count_o
);
    import cache_pkg::*;

    ctrl_state_e  state_q;
    ctrl_state_e  state_d;
    cache_req_t   req_q;          // Captured in the setup phase
    logic         err_q;          // Illegal strobe seen at setup
    logic         wt_start_q;     // Write-through due in the cycle after a write fill
    access_size_e size_dec;
    logic         strb_bad;
    logic         setup;
    logic         l2_valid;
    logic         l2_we;
    logic         cnt_hit;
    logic         cnt_miss;

    assign setup = psel_i && !penable_i;

    // PSTRB decode
    always_comb begin
        size_dec = SZ_WORD;                       // Reads always return the full word
        strb_bad = 1'b0;
        if (pwrite_i) begin
            case (pstrb_i)
                4'b0001: size_dec = SZ_BYTE;
                4'b0011: size_dec = SZ_HALF;
                4'b1111: size_dec = SZ_WORD;
                default: strb_bad = 1'b1;         // All-zero strobes land here too
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && setup) begin
            req_q <= '{addr: paddr_i, wdata: pwdata_i, size: size_dec, wr: pwrite_i};
        end
    end

    // Sequencer
    always_comb begin
        state_d   = state_q;
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        touch_o   = 1'b0;
        wr_hit_o  = 1'b0;
        fill_o    = 1'b0;
        l2_valid  = 1'b0;
        l2_we     = 1'b0;
        cnt_hit   = 1'b0;
        cnt_miss  = 1'b0;
        case (state_q)
            ST_IDLE: if (setup) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (err_q) begin                  // No array, L2 or counter side effects
                    pready_o  = 1'b1;
                    pslverr_o = 1'b1;
                    state_d   = ST_IDLE;
                end else if (hit_i) begin
                    touch_o = 1'b1;
                    cnt_hit = 1'b1;
                    if (req_q.wr) begin
                        wr_hit_o = 1'b1;          // Array updated alongside the write-through
                        l2_valid = 1'b1;
                        l2_we    = 1'b1;
                        state_d  = ST_WT_WAIT;
                    end else begin
                        pready_o = 1'b1;          // Read hit, zero wait
                        state_d  = ST_IDLE;
                    end
                end else begin
                    l2_valid = 1'b1;              // Line fetch for read and write misses
                    cnt_miss = 1'b1;
                    state_d  = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                if (l2_rsp_i.valid) begin
                    fill_o  = 1'b1;
                    state_d = req_q.wr ? ST_WT_WAIT : ST_DONE;
                end
            end
            ST_WT_WAIT: begin
                l2_valid = wt_start_q;            // Only set on the write-miss path
                l2_we    = 1'b1;
                if (l2_rsp_i.valid) state_d = ST_DONE;
            end
            ST_DONE: begin
                pready_o = 1'b1;
                state_d  = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            err_q      <= 1'b0;
            wt_start_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            wt_start_q <= state_q == ST_FILL_WAIT && l2_rsp_i.valid && req_q.wr;
            if (state_q == ST_IDLE && setup) err_q <= strb_bad;
        end
    end

    // Saturating event counters
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            if (cnt_hit && hit_count_o != '1) hit_count_o <= hit_count_o + 1'b1;
            if (cnt_miss && miss_count_o != '1) miss_count_o <= miss_count_o + 1'b1;
        end
    end

    assign req_o       = req_q;
    assign prdata_o    = rd_data_i;               // After a fill the array already holds the L2 word
    assign fill_data_o = l2_rsp_i.rdata;
    assign l2_req_o    = '{valid: l2_valid, we: l2_we, addr: req_q.addr,
                           wdata: req_q.wdata, size: req_q.size};

endmodule

`default_nettype wire

// File: cache_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_subsys_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`CACHE_ADDR_W-1:0]  paddr_i,
    input  logic [`CACHE_DATA_W-1:0]  pwdata_i,
    input  logic [`CACHE_STRB_W-1:0]  pstrb_i,
    output logic [`CACHE_DATA_W-1:0]  prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output logic [`CACHE_CNT_W-1:0]   hit_count_o,
    output logic [`CACHE_CNT_W-1:0]   miss_count_o
);
    import cache_pkg::*;

    cache_req_t               req;          // Controller to array
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] rd_data;
    logic                     touch;
    logic                     wr_hit;
    logic                     fill;
    logic [`CACHE_DATA_W-1:0] fill_data;
    l2_req_t                  l2_req;       // Controller to L2
    l2_rsp_t                  l2_rsp;

    // APB slave and miss sequencer
    cache_apb_ctrl i_cache_apb_ctrl (
        .clk,
        .rst_i,
        .psel_i,
        .penable_i,
        .pwrite_i,
        .paddr_i,
        .pwdata_i,
        .pstrb_i,
        .prdata_o,
        .pready_o,
        .pslverr_o,
        .req_o        (req),
        .hit_i        (hit),
        .rd_data_i    (rd_data),
        .touch_o      (touch),
        .wr_hit_o     (wr_hit),
        .fill_o       (fill),
        .fill_data_o  (fill_data),
        .l2_req_o     (l2_req),
        .l2_rsp_i     (l2_rsp),
        .hit_count_o,
        .miss_count_o
    );

    l1_cache_array i_l1_cache_array (
        .clk,
        .rst_i,
        .req_i        (req),
        .touch_i      (touch),
        .wr_hit_i     (wr_hit),
        .fill_i       (fill),
        .fill_data_i  (fill_data),
        .hit_o        (hit),
        .rd_data_o    (rd_data)
    );

    l2_backing_mem i_l2_backing_mem (
        .clk,
        .rst_i,
        .req_i        (l2_req),
        .rsp_o        (l2_rsp)
    );

endmodule

`default_nettype wire

// File: cache_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_subsys_chk (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`CACHE_ADDR_W-1:0]  paddr_i,
    input  logic [`CACHE_DATA_W-1:0]  pwdata_i,
    input  logic [`CACHE_STRB_W-1:0]  pstrb_i,
    input  logic                      pready_i,
    input  logic                      pslverr_i,
    input  cache_pkg::l2_req_t        l2_req_i,
    input  cache_pkg::l2_rsp_t        l2_rsp_i
);
    logic l2_busy_q;    // An L2 request is in flight

    always_ff @(posedge clk) begin
        if (rst_i) begin
            l2_busy_q <= 1'b0;
        end else if (l2_req_i.valid) begin
            l2_busy_q <= 1'b1;
        end else if (l2_rsp_i.valid) begin
            l2_busy_q <= 1'b0;
        end
    end

    // Completion only in the access phase
    apb_ready_in_access: assert property (@(posedge clk) disable iff (rst_i)
        (pready_i || pslverr_i) |-> (psel_i && penable_i))
        else $error("PREADY or PSLVERR high outside an APB access phase");

    apb_inputs_stable: assert property (@(posedge clk) disable iff (rst_i)
        (psel_i && !pready_i) |=> $stable({pwrite_i, paddr_i, pwdata_i, pstrb_i}))
        else $error("APB inputs changed while the transfer was pending");

    // At most one L2 request outstanding from the controller
    l2_single_outstanding: assert property (@(posedge clk) disable iff (rst_i)
        l2_req_i.valid |-> !l2_busy_q)
        else $error("L2 request issued before the previous response returned");

endmodule

bind cache_subsys_top cache_subsys_chk i_cache_subsys_chk (
    .clk       (clk),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .l2_req_i  (l2_req),
    .l2_rsp_i  (l2_rsp)
);

`default_nettype wire

// File: tb_cache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tb_cache_subsys;

    localparam int L       = `CACHE_L2_LAT + 1;    // Wait cycles per L2 round trip
    localparam int TIMEOUT = 100;                  // Cycles allowed for PREADY

    logic                      clk;
    logic                      rst_i;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`CACHE_ADDR_W-1:0]  paddr;
    logic [`CACHE_DATA_W-1:0]  pwdata;
    logic [`CACHE_STRB_W-1:0]  pstrb;
    logic [`CACHE_DATA_W-1:0]  prdata;
    logic                      pready;
    logic                      pslverr;
    logic [`CACHE_CNT_W-1:0]   hit_count;
    logic [`CACHE_CNT_W-1:0]   miss_count;

    // Reference model of the L2 image and the per-set tags, valids and ages
    logic [`CACHE_DATA_W-1:0] mem_model [`CACHE_L2_DEPTH];
    logic [`CACHE_TAG_W-1:0]  tag_model [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic                     vld_model [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic [`CACHE_AGE_W-1:0]  age_model [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    int                       hits;
    int                       misses;
    logic [31:0]              lcg_state = 32'd39728;

    cache_subsys_top i_cache_subsys_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .pstrb_i      (pstrb),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .hit_count_o  (hit_count),
        .miss_count_o (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_counters(input string name);
        check({name, " hit_count"}, hits, 32'(hit_count));
        check({name, " miss_count"}, misses, 32'(miss_count));
    endtask

    // One APB transfer with outputs sampled on the falling edge
    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output int waits, output logic err);
        @(negedge clk);
        psel    = 1'b1;                            // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        @(negedge clk);
        penable = 1'b1;                            // Access phase
        waits   = 0;
        while (!pready) begin
            if (waits >= TIMEOUT) begin
                $display("Timeout: PREADY never rose for address %h", addr);
                $display("Simulation failed");
                $fatal(1);
            end
            @(negedge clk);
            waits++;
        end
        rdata = prdata;                            // Transfer completes on the next rising edge
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Lookup, LRU update and write-through on the reference state
    task automatic model_access(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] exp_rdata, output int exp_waits);
        logic [`CACHE_IDX_W-1:0]    s;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_L2_IDX_W-1:0] widx;
        logic                       hit;
        int                         way;
        s    = addr[9:2];
        tag  = {addr[31:10], addr[1:0]};           // Low address bits are part of the tag
        widx = addr[13:2];
        hit  = 1'b0;
        way  = 0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (!hit && vld_model[s][w] && tag_model[s][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (hit) begin
            hits++;
        end else begin
            way = 0;                               // Lowest way among the oldest
            for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
                if (age_model[s][w] > age_model[s][way]) way = w;
            end
            vld_model[s][way] = 1'b1;
            tag_model[s][way] = tag;
            misses++;
        end
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (w == way) age_model[s][w] = '0;
            else if (age_model[s][w] < `CACHE_AGE_MAX) age_model[s][w] = age_model[s][w] + 3'd1;
        end
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) mem_model[widx][8*b +: 8] = wdata[8*b +: 8];   // Byte lanes
            end
        end
        exp_rdata = mem_model[widx];
        exp_waits = wr ? (hit ? L : 2 * L) : (hit ? 0 : L);
    endtask

    task automatic do_access(input string name, input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             output int waits);
        logic [31:0] exp_rdata;
        int          exp_waits;
        logic [31:0] rdata;
        logic        err;
        model_access(wr, addr, wdata, strb, exp_rdata, exp_waits);
        apb_access(wr, addr, wdata, strb, rdata, waits, err);
        check({name, " pslverr"}, 32'd0, 32'(err));
        check({name, " waits"}, exp_waits, waits);
        if (!wr) check({name, " rdata"}, exp_rdata, rdata);
        check_counters(name);
    endtask

    task automatic cold_read_then_hit();
        int w;
        do_access("cold_read miss", 1'b0, 32'h0000_0100, '0, 4'h0, w);
        check("cold_read miss waits", L, w);
        do_access("cold_read hit", 1'b0, 32'h0000_0100, '0, 4'h0, w);
        check("cold_read hit waits", 0, w);
    endtask

    task automatic write_widths();
        int w;
        // Line at 0x100 is resident after the cold read
        do_access("wr_word hit", 1'b1, 32'h0000_0100, 32'h1122_3344, 4'b1111, w);
        check("wr_word hit waits", L, w);
        do_access("wr_half hit", 1'b1, 32'h0000_0100, 32'hAAAA_5566, 4'b0011, w);
        do_access("wr_byte hit", 1'b1, 32'h0000_0100, 32'hBBBB_BB77, 4'b0001, w);
        do_access("wr_hit readback", 1'b0, 32'h0000_0100, '0, 4'h0, w);
        check("wr_hit readback waits", 0, w);
        do_access("wr_word miss", 1'b1, 32'h0000_0204, 32'hCAFE_F00D, 4'b1111, w);
        check("wr_word miss waits", 2 * L, w);
        do_access("wr_half miss", 1'b1, 32'h0000_0208, 32'h1234_ABCD, 4'b0011, w);
        do_access("wr_byte miss", 1'b1, 32'h0000_020C, 32'h5678_9AEF, 4'b0001, w);
        for (int i = 0; i < 3; i++) begin
            do_access("wr_miss readback", 1'b0, 32'h0000_0204 + 32'(4 * i), '0, 4'h0, w);
            check("wr_miss readback waits", 0, w);
        end
    endtask

    task automatic lru_eviction();
        logic [31:0] base;
        int          w;
        base = 32'h0000_0014;                      // Set 5 with tags differing in addr[12:10]
        for (int t = 0; t < 4; t++) begin
            do_access("lru fill", 1'b1, base | (32'(t) << 10),
                      32'hC0DE_0000 + 32'(t), 4'b1111, w);
        end
        do_access("lru reread t0", 1'b0, base, '0, 4'h0, w);
        check("lru reread t0 waits", 0, w);
        do_access("lru t4", 1'b0, base | 32'h0000_1000, '0, 4'h0, w);   // Oldest is t1
        check("lru t4 waits", L, w);
        do_access("lru t0 kept", 1'b0, base, '0, 4'h0, w);
        check("lru t0 kept waits", 0, w);
        do_access("lru t1 evicted", 1'b0, base | 32'h0000_0400, '0, 4'h0, w);
        check("lru t1 evicted waits", L, w);       // Data comes back from L2
    endtask

    task automatic bad_strobe_error();
        logic [31:0] rdata;
        logic        err;
        int          w;
        for (int i = 0; i < 2; i++) begin
            apb_access(1'b1, 32'h0000_0100, 32'hDEAD_BEEF, (i == 0) ? 4'b0100 : 4'b0000,
                       rdata, w, err);
            check("bad_strobe pslverr", 1, 32'(err));
            check("bad_strobe waits", 0, w);
            check_counters("bad_strobe");
        end
        do_access("bad_strobe readback", 1'b0, 32'h0000_0100, '0, 4'h0, w);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          w;
        for (int i = 0; i < 60; i++) begin
            r    = lcg_next();
            data = lcg_next();
            addr = ((32'(r[18:16]) % 32'd6) << 10) | (32'(r[5:4]) << 2);   // Six tags over four sets
            case (r[25:24])
                2'd0:    strb = 4'b0001;
                2'd1:    strb = 4'b0011;
                default: strb = 4'b1111;
            endcase
            do_access("random", r[30], addr, data, r[30] ? strb : 4'h0, w);
        end
    endtask

    initial begin
        rst_i   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        hits    = 0;
        misses  = 0;
        for (int i = 0; i < `CACHE_L2_DEPTH; i++) mem_model[i] = '0;   // L2 starts zeroed
        for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                tag_model[s][w] = '0;
                vld_model[s][w] = 1'b0;
                age_model[s][w] = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        cold_read_then_hit();
        write_widths();
        lru_eviction();
        bad_strobe_error();
        random_mix();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
cache_pkg.sv
l1_cache_array.sv
l2_backing_mem.sv
cache_apb_ctrl.sv
cache_subsys_top.sv
cache_subsys_chk.sv
tb_cache_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_subsys
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
